//--- Bender.yml
package:
  name: vga_gfx

sources:
  - logic/vga_gfx_pkg.sv
  - logic/vga_gfx_regs.sv
  - logic/vga_gfx_write.sv
  - logic/vga_gfx_planes.sv
  - logic/vga_gfx_read.sv
  - logic/vga_gfx.sv
  - target: test
    files:
      - dv/vga_gfx_model.sv
      - dv/vga_gfx_tb.sv

//--- dv/vga_gfx_model.sv
// Graphics controller reference model
package vga_gfx_model;
  import vga_gfx_pkg::*;

  logic [31:0] lfsr_state = 32'hb962f8fc;
  logic [7:0]  index_m;
  logic [7:0]  regs_m   [256];
  logic [7:0]  planes_m [PLANES][2**PLANE_AW];
  logic [7:0]  latch_m  [PLANES];

  // Galois LFSR with taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return bits;
  endfunction

  // Bits of each register that are stored and read back
  function automatic logic [7:0] stored_bits(input logic [7:0] idx);
    case (idx)
      GR_SET_RESET, GR_ENABLE_SR, GR_COLOR_COMPARE, GR_DONT_CARE, GR_MAP_MASK: return 8'h0F;
      GR_DATA_ROTATE: return 8'h18;
      GR_READ_MAP:    return 8'h03;
      GR_MODE:        return 8'h0B;
      GR_BIT_MASK:    return 8'hFF;
      default:        return 8'h00;
    endcase
  endfunction

  function automatic void reset_regs();
    index_m = '0;
    foreach (regs_m[i]) begin
      regs_m[i] = '0;
    end
    regs_m[GR_BIT_MASK] = BIT_MASK_RST;
    regs_m[GR_MAP_MASK] = {4'h0, MAP_MASK_RST};
  endfunction

  // Low lane moves the index before the high lane writes
  function automatic void cfg_write(input logic [1:0] sel, input logic [15:0] word);
    if (sel[0]) index_m = word[7:0];
    if (sel[1]) regs_m[index_m] = word[15:8] & stored_bits(index_m);
  endfunction

  function automatic logic [15:0] cfg_read_word();
    return {regs_m[index_m], index_m};
  endfunction

  function automatic void mem_write(input logic [7:0] adr, input logic [7:0] cpu);
    logic [1:0] mode;
    logic [7:0] mask;
    logic [7:0] src;
    logic [7:0] res;
    mode = regs_m[GR_MODE][1:0];
    mask = regs_m[GR_BIT_MASK];
    for (int p = 0; p < PLANES; p++) begin
      // Mode 3 takes the mode 0 path
      src = (mode == 2'd2) ? {8{cpu[p]}} :
            regs_m[GR_ENABLE_SR][p] ? {8{regs_m[GR_SET_RESET][p]}} : cpu;
      case (regs_m[GR_DATA_ROTATE][4:3])
        ROP_AND: res = src & latch_m[p];
        ROP_OR:  res = src | latch_m[p];
        ROP_XOR: res = src ^ latch_m[p];
        default: res = src;
      endcase
      res = (mode == 2'd1) ? latch_m[p] : (res & mask) | (latch_m[p] & ~mask);
      if (regs_m[GR_MAP_MASK][p]) planes_m[p][adr] = res;
    end
  endfunction

  // Every read reloads all four latches
  function automatic logic [7:0] mem_read(input logic [7:0] adr);
    logic [7:0] res;
    for (int p = 0; p < PLANES; p++) begin
      latch_m[p] = planes_m[p][adr];
    end
    if (!regs_m[GR_MODE][3]) return latch_m[regs_m[GR_READ_MAP][1:0]];
    res = 8'hFF;
    // Only planes with their don't-care bit set take part
    for (int b = 0; b < 8; b++) begin
      for (int p = 0; p < PLANES; p++) begin
        if (regs_m[GR_DONT_CARE][p] && latch_m[p][b] != regs_m[GR_COLOR_COMPARE][p]) begin
          res[b] = 1'b0;
        end
      end
    end
    return res;
  endfunction

endpackage

//--- dv/vga_gfx_tb.sv
// VGA graphics controller testbench
`timescale 1ns/1ps

module vga_gfx_tb import vga_gfx_pkg::*, vga_gfx_model::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int N_CFG      = 24;
  localparam int N_MIX      = 64;
  localparam int N_COPY     = 32;
  localparam int N_CMP      = 64;
  localparam int SWEEP      = 1 + 4 * 257;
  localparam int ACCESSES   = 32 + 2 * N_CFG + 261 + 9 * N_MIX + 1 + 3 * N_COPY +
                              1 + 3 * N_CMP + 2 + 3 * SWEEP;

  logic        wb_clk_i;
  logic        rst_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic [16:1] wb_adr_i;
  logic        wb_we_i;
  logic        wb_tga_i;
  logic [1:0]  wb_sel_i;
  logic        wb_stb_i;
  logic        wb_cyc_i;
  logic        wb_ack_o;
  logic [15:0] rd_word;
  bit          hold_ack;

  vga_gfx DUT (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
  end

  // Ten cycles per access is ample
  initial begin
    #(CLK_PERIOD * (10 * ACCESSES + 8));
    $display("Timeout: the acknowledge never arrived");
    stop_with_failure();
  end

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // Latency counts edges after the accepting edge
  task automatic bus_cycle(input logic tga, input logic we, input logic [7:0] adr,
                           input logic [1:0] sel, input logic [15:0] data);
    int lat;
    @(posedge wb_clk_i);
    #1;
    wb_tga_i = tga;
    wb_we_i  = we;
    wb_adr_i = {9'h000, adr[7:1]};
    wb_sel_i = sel;
    wb_dat_i = data;
    wb_stb_i = 1'b1;
    wb_cyc_i = 1'b1;
    lat = -1;
    do begin
      @(posedge wb_clk_i);
      #1;
      lat++;
    end while (!wb_ack_o);
    rd_word = wb_dat_o;
    check_value("wb_ack_o latency", 16'(lat), tga ? 16'd1 : 16'd2);
    if (hold_ack) begin
      @(posedge wb_clk_i);
      #1;
      check_value("wb_ack_o", {15'h0, wb_ack_o}, 16'h0000);
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      // A stray second acceptance would acknowledge within two cycles
      repeat (2) begin
        @(posedge wb_clk_i);
        #1;
        check_value("wb_ack_o", {15'h0, wb_ack_o}, 16'h0000);
      end
    end
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
  endtask

  task automatic set_cfg(input logic [1:0] sel, input logic [7:0] idx, input logic [7:0] val);
    bus_cycle(1'b1, 1'b1, 8'h00, sel, {val, idx});
    cfg_write(sel, {val, idx});
  endtask

  task automatic check_cfg();
    bus_cycle(1'b1, 1'b0, 8'h00, 2'b11, 16'h0000);
    check_value("wb_dat_o", rd_word, cfg_read_word());
  endtask

  // Byte on the selected lane and its inverse on the other
  task automatic write_byte(input logic [7:0] adr, input logic [7:0] val);
    bus_cycle(1'b0, 1'b1, adr, adr[0] ? 2'b10 : 2'b01,
              adr[0] ? {val, ~val} : {~val, val});
    mem_write(adr, val);
  endtask

  task automatic read_byte(input logic [7:0] adr);
    logic [7:0] exp;
    bus_cycle(1'b0, 1'b0, adr, adr[0] ? 2'b10 : 2'b01, 16'h0000);
    exp = mem_read(adr);
    check_value("wb_dat_o", rd_word, adr[0] ? {exp, 8'h00} : {8'h00, exp});
  endtask

  task automatic check_all_maps();
    set_cfg(2'b11, GR_MODE, 8'h00);
    for (int m = 0; m < PLANES; m++) begin
      set_cfg(2'b11, GR_READ_MAP, 8'(m));
      for (int a = 0; a < 256; a++) begin
        read_byte(8'(a));
      end
    end
  endtask

  initial begin
    logic [1:0] sel;
    logic [7:0] idx;
    logic [7:0] adr;
    rst_i    = 1'b1;
    wb_dat_i = '0;
    wb_adr_i = '0;
    wb_we_i  = 1'b0;
    wb_tga_i = 1'b0;
    wb_sel_i = 2'b00;
    wb_stb_i = 1'b0;
    wb_cyc_i = 1'b0;
    hold_ack = 1'b0;
    reset_regs();
    repeat (8) @(posedge wb_clk_i);
    #1;
    rst_i = 1'b0;

    // Reset values, then random lane mixes
    for (int i = 0; i < 16; i++) begin
      set_cfg(2'b01, 8'(i), 8'(take_bits(8)));
      check_cfg();
    end
    for (int i = 0; i < N_CFG; i++) begin
      sel = 2'(take_bits(2));
      if (sel == 2'b00) sel = 2'b11;
      idx = 8'(take_bits(4));
      set_cfg(sel, idx, 8'(take_bits(8)));
      check_cfg();
    end

    // Plain fill
    set_cfg(2'b11, GR_MODE, 8'h00);
    set_cfg(2'b11, GR_ENABLE_SR, 8'h00);
    set_cfg(2'b11, GR_DATA_ROTATE, 8'h00);
    set_cfg(2'b11, GR_BIT_MASK, 8'hFF);
    set_cfg(2'b11, GR_MAP_MASK, 8'h0F);
    for (int a = 0; a < 256; a++) begin
      write_byte(8'(a), 8'(take_bits(8)));
    end
    check_all_maps();

    // Modes 0 and 2 with random set/reset, ALU and masks
    for (int i = 0; i < N_MIX; i++) begin
      set_cfg(2'b11, GR_SET_RESET, 8'(take_bits(8)));
      set_cfg(2'b11, GR_ENABLE_SR, 8'(take_bits(8)));
      set_cfg(2'b11, GR_DATA_ROTATE, 8'(take_bits(8)));
      set_cfg(2'b11, GR_MODE, {6'h00, 1'(take_bits(1)), 1'b0});
      set_cfg(2'b11, GR_BIT_MASK, 8'(take_bits(8)));
      set_cfg(2'b11, GR_MAP_MASK, 8'(take_bits(8)));
      set_cfg(2'b11, GR_READ_MAP, 8'(take_bits(8)));
      adr = 8'(take_bits(8));
      read_byte(adr);
      write_byte(adr, 8'(take_bits(8)));
    end
    check_all_maps();

    // Latch copies in mode 1
    set_cfg(2'b11, GR_MODE, 8'h01);
    for (int i = 0; i < N_COPY; i++) begin
      set_cfg(2'b11, GR_MAP_MASK, 8'(take_bits(8)));
      read_byte(8'(take_bits(8)));
      adr = 8'(take_bits(8));
      write_byte(adr, 8'(take_bits(8)));
    end
    check_all_maps();

    // Colour compare
    set_cfg(2'b11, GR_MODE, 8'h08);
    for (int i = 0; i < N_CMP; i++) begin
      set_cfg(2'b11, GR_COLOR_COMPARE, 8'(take_bits(8)));
      set_cfg(2'b11, GR_DONT_CARE, 8'(take_bits(8)));
      read_byte(8'(take_bits(8)));
    end

    // Strobe held past the acknowledge
    hold_ack = 1'b1;
    check_cfg();
    read_byte(8'(take_bits(8)));
    hold_ack = 1'b0;

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- logic/vga_gfx.sv
// VGA graphics controller top
`timescale 1ns/1ps

module vga_gfx import vga_gfx_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        rst_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  input  logic [16:1] wb_adr_i,
  input  logic        wb_we_i,
  input  logic        wb_tga_i,
  input  logic [1:0]  wb_sel_i,
  input  logic        wb_stb_i,
  input  logic        wb_cyc_i,
  output logic        wb_ack_o
);

  logic [7:0]          cpu_byte;
  logic [PLANE_AW-1:0] plane_adr;
  logic                mem_wr;
  logic                mem_rd;
  logic                lane_hi;
  logic                cfg_done;
  logic                mem_done;
  logic [15:0]         cfg_rdata;
  logic [3:0]          set_reset;
  logic [3:0]          enable_set_reset;
  logic [1:0]          raster_op;
  logic [1:0]          write_mode;
  logic                read_mode;
  logic [1:0]          read_map_select;
  logic [3:0]          color_compare;
  logic [3:0]          color_dont_care;
  logic [7:0]          bit_mask;
  logic [3:0]          map_mask;
  logic [8*PLANES-1:0] plane_wdata;
  logic [PLANES-1:0]   plane_we;
  logic [8*PLANES-1:0] latch;
  logic                latch_valid;

  vga_gfx_regs u_regs (
    .wb_clk_i, .rst_i, .wb_dat_i, .wb_adr_i, .wb_we_i, .wb_tga_i, .wb_sel_i,
    .wb_stb_i, .wb_cyc_i,
    .cpu_byte_o         (cpu_byte),
    .plane_adr_o        (plane_adr),
    .mem_wr_o           (mem_wr),
    .mem_rd_o           (mem_rd),
    .lane_hi_o          (lane_hi),
    .cfg_done_o         (cfg_done),
    .mem_done_o         (mem_done),
    .cfg_rdata_o        (cfg_rdata),
    .set_reset_o        (set_reset),
    .enable_set_reset_o (enable_set_reset),
    .raster_op_o        (raster_op),
    .write_mode_o       (write_mode),
    .read_mode_o        (read_mode),
    .read_map_select_o  (read_map_select),
    .color_compare_o    (color_compare),
    .color_dont_care_o  (color_dont_care),
    .bit_mask_o         (bit_mask),
    .map_mask_o         (map_mask)
  );

  vga_gfx_write u_write (
    .wb_clk_i, .rst_i,
    .mem_wr_i           (mem_wr),
    .cpu_byte_i         (cpu_byte),
    .latch_i            (latch),
    .set_reset_i        (set_reset),
    .enable_set_reset_i (enable_set_reset),
    .raster_op_i        (raster_op),
    .write_mode_i       (write_mode),
    .bit_mask_i         (bit_mask),
    .map_mask_i         (map_mask),
    .plane_wdata_o      (plane_wdata),
    .plane_we_o         (plane_we)
  );

  vga_gfx_planes u_planes (
    .wb_clk_i, .rst_i,
    .plane_adr_i   (plane_adr),
    .mem_rd_i      (mem_rd),
    .plane_wdata_i (plane_wdata),
    .plane_we_i    (plane_we),
    .latch_o       (latch),
    .latch_valid_o (latch_valid)
  );

  vga_gfx_read u_read (
    .wb_clk_i, .rst_i,
    .latch_i           (latch),
    .latch_valid_i     (latch_valid),
    .read_mode_i       (read_mode),
    .read_map_select_i (read_map_select),
    .color_compare_i   (color_compare),
    .color_dont_care_i (color_dont_care),
    .cfg_rdata_i       (cfg_rdata),
    .lane_hi_i         (lane_hi),
    .cfg_done_i        (cfg_done),
    .mem_done_i        (mem_done),
    .wb_dat_o,
    .wb_ack_o
  );

endmodule

//--- logic/vga_gfx_pkg.sv
// VGA graphics controller definitions
package vga_gfx_pkg;

  // Plane store geometry
  localparam int PLANES   = 4;
  localparam int PLANE_AW = 8;

  // Graphics register indices
  localparam logic [7:0] GR_SET_RESET     = 8'd0;
  localparam logic [7:0] GR_ENABLE_SR     = 8'd1;
  localparam logic [7:0] GR_COLOR_COMPARE = 8'd2;
  localparam logic [7:0] GR_DATA_ROTATE   = 8'd3;
  localparam logic [7:0] GR_READ_MAP      = 8'd4;
  localparam logic [7:0] GR_MODE          = 8'd5;
  localparam logic [7:0] GR_DONT_CARE     = 8'd7;
  localparam logic [7:0] GR_BIT_MASK      = 8'd8;

  // Sequencer map mask, folded into the graphics index space
  localparam logic [7:0] GR_MAP_MASK      = 8'd9;

  // Raster operations, data rotate bits 4:3
  localparam logic [1:0] ROP_NONE = 2'd0;
  localparam logic [1:0] ROP_AND  = 2'd1;
  localparam logic [1:0] ROP_OR   = 2'd2;
  localparam logic [1:0] ROP_XOR  = 2'd3;

  // Non-zero reset values
  localparam logic [7:0] BIT_MASK_RST = 8'hFF;
  localparam logic [3:0] MAP_MASK_RST = 4'hF;

  // Config port word
  // Raw for read-back, index and value for a write
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [7:0] value;
      logic [7:0] index;
    } pair;
  } vga_cfg_word_u;

endpackage

//--- logic/vga_gfx_planes.sv
// Bit plane store and latches
`timescale 1ns/1ps

module vga_gfx_planes import vga_gfx_pkg::*; (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  logic [PLANE_AW-1:0] plane_adr_i,
  input  logic                mem_rd_i,
  input  logic [8*PLANES-1:0] plane_wdata_i,
  input  logic [PLANES-1:0]   plane_we_i,
  output logic [8*PLANES-1:0] latch_o,
  output logic                latch_valid_o
);

  logic [7:0]          plane_mem [PLANES][2**PLANE_AW];
  logic [PLANE_AW-1:0] adr_q;

  // Address as seen at acceptance, aligned with the strobes
  always_ff @(posedge wb_clk_i) begin
    adr_q <= plane_adr_i;
  end

  always_ff @(posedge wb_clk_i) begin
    for (int p = 0; p < PLANES; p++) begin
      if (plane_we_i[p]) begin
        plane_mem[p][adr_q] <= plane_wdata_i[8*p +: 8];
      end
    end
  end

  // All four planes land in the latches on every read
  always_ff @(posedge wb_clk_i) begin
    if (mem_rd_i) begin
      for (int p = 0; p < PLANES; p++) begin
        latch_o[8*p +: 8] <= plane_mem[p][adr_q];
      end
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      latch_valid_o <= 1'b0;
    end else begin
      latch_valid_o <= mem_rd_i;
    end
  end

endmodule

//--- logic/vga_gfx_read.sv
// Graphics controller read result
`timescale 1ns/1ps

module vga_gfx_read import vga_gfx_pkg::*; (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  logic [8*PLANES-1:0] latch_i,
  input  logic                latch_valid_i,
  input  logic                read_mode_i,
  input  logic [1:0]          read_map_select_i,
  input  logic [PLANES-1:0]   color_compare_i,
  input  logic [PLANES-1:0]   color_dont_care_i,
  input  logic [15:0]         cfg_rdata_i,
  input  logic                lane_hi_i,
  input  logic                cfg_done_i,
  input  logic                mem_done_i,
  output logic [15:0]         wb_dat_o,
  output logic                wb_ack_o
);

  logic [PLANES-1:0] pix [8];
  logic [7:0]        cmp_byte;
  logic [7:0]        map_byte;
  logic [7:0]        mem_byte;

  // Colour compare across planes, one pixel per bit
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      for (int p = 0; p < PLANES; p++) begin
        pix[b][p] = latch_i[8*p + b];
      end
      cmp_byte[b] = &(~(pix[b] ^ color_compare_i) | ~color_dont_care_i);
    end
  end

  assign map_byte = latch_i[8*read_map_select_i +: 8];

  // Writes leave the latches alone and return zero
  assign mem_byte = !latch_valid_i ? 8'h00 :
                    read_mode_i    ? cmp_byte : map_byte;

  always_ff @(posedge wb_clk_i) begin
    if (cfg_done_i) begin
      wb_dat_o <= cfg_rdata_i;
    end else if (mem_done_i) begin
      wb_dat_o <= lane_hi_i ? {mem_byte, 8'h00} : {8'h00, mem_byte};
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= cfg_done_i | mem_done_i;
    end
  end

  a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

//--- logic/vga_gfx_regs.sv
// Graphics controller bus decode
`timescale 1ns/1ps

module vga_gfx_regs import vga_gfx_pkg::*; (
  input  logic                wb_clk_i,
  input  logic                rst_i,
  input  logic [15:0]         wb_dat_i,
  input  logic [16:1]         wb_adr_i,
  input  logic                wb_we_i,
  input  logic                wb_tga_i,
  input  logic [1:0]          wb_sel_i,
  input  logic                wb_stb_i,
  input  logic                wb_cyc_i,
  output logic [7:0]          cpu_byte_o,
  output logic [PLANE_AW-1:0] plane_adr_o,
  output logic                mem_wr_o,
  output logic                mem_rd_o,
  output logic                lane_hi_o,
  output logic                cfg_done_o,
  output logic                mem_done_o,
  output logic [15:0]         cfg_rdata_o,
  output logic [3:0]          set_reset_o,
  output logic [3:0]          enable_set_reset_o,
  output logic [1:0]          raster_op_o,
  output logic [1:0]          write_mode_o,
  output logic                read_mode_o,
  output logic [1:0]          read_map_select_o,
  output logic [3:0]          color_compare_o,
  output logic [3:0]          color_dont_care_o,
  output logic [7:0]          bit_mask_o,
  output logic [3:0]          map_mask_o
);

  logic          accept;
  logic          cfg_acc;
  logic          mem_acc;
  logic          pending;
  logic          mem_acc_q;
  logic          done_q;
  logic          cfg_wr_q;
  logic [1:0]    cfg_sel_q;
  logic [7:0]    index;
  logic [7:0]    wr_index;
  vga_cfg_word_u cfg_word_q;
  vga_cfg_word_u rd_word;

  // One access in flight; the latches make order matter
  assign accept  = wb_stb_i & wb_cyc_i & ~pending;
  assign cfg_acc = accept & wb_tga_i;
  assign mem_acc = accept & ~wb_tga_i;

  assign mem_wr_o    = mem_acc & wb_we_i;
  assign cpu_byte_o  = wb_sel_i[1] ? wb_dat_i[15:8] : wb_dat_i[7:0];
  assign plane_adr_o = {wb_adr_i[7:1], wb_sel_i[1]};

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      pending    <= 1'b0;
      cfg_done_o <= 1'b0;
      cfg_wr_q   <= 1'b0;
      mem_acc_q  <= 1'b0;
      mem_done_o <= 1'b0;
      mem_rd_o   <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      if (accept) begin
        pending <= 1'b1;
      end else if (done_q) begin
        pending <= 1'b0;
      end
      cfg_done_o <= cfg_acc;
      cfg_wr_q   <= cfg_acc & wb_we_i & (wb_adr_i == '0);
      mem_acc_q  <= mem_acc;
      mem_done_o <= mem_acc_q;
      mem_rd_o   <= mem_acc & ~wb_we_i;
      // Mirrors the acknowledge cycle
      done_q     <= cfg_done_o | mem_done_o;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      lane_hi_o      <= wb_sel_i[1];
      cfg_sel_q      <= wb_sel_i;
      cfg_word_q.raw <= wb_dat_i;
    end
  end

  // Both lanes: the new index takes the value
  assign wr_index = cfg_sel_q[0] ? cfg_word_q.pair.index : index;

  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      index              <= '0;
      set_reset_o        <= '0;
      enable_set_reset_o <= '0;
      color_compare_o    <= '0;
      raster_op_o        <= '0;
      read_map_select_o  <= '0;
      write_mode_o       <= '0;
      read_mode_o        <= 1'b0;
      color_dont_care_o  <= '0;
      bit_mask_o         <= BIT_MASK_RST;
      map_mask_o         <= MAP_MASK_RST;
    end else if (cfg_wr_q) begin
      if (cfg_sel_q[0]) begin
        index <= cfg_word_q.pair.index;
      end
      if (cfg_sel_q[1]) begin
        case (wr_index)
          GR_SET_RESET:     set_reset_o        <= cfg_word_q.pair.value[3:0];
          GR_ENABLE_SR:     enable_set_reset_o <= cfg_word_q.pair.value[3:0];
          GR_COLOR_COMPARE: color_compare_o    <= cfg_word_q.pair.value[3:0];
          GR_DATA_ROTATE:   raster_op_o        <= cfg_word_q.pair.value[4:3];
          GR_READ_MAP:      read_map_select_o  <= cfg_word_q.pair.value[1:0];
          GR_MODE: begin
            write_mode_o <= cfg_word_q.pair.value[1:0];
            read_mode_o  <= cfg_word_q.pair.value[3];
          end
          GR_DONT_CARE:     color_dont_care_o  <= cfg_word_q.pair.value[3:0];
          GR_BIT_MASK:      bit_mask_o         <= cfg_word_q.pair.value;
          GR_MAP_MASK:      map_mask_o         <= cfg_word_q.pair.value[3:0];
          default: ;
        endcase
      end
    end
  end

  // Read-back: index in lane 0, indexed register in lane 1
  always_comb begin
    rd_word.pair.index = index;
    rd_word.pair.value = '0;
    case (index)
      GR_SET_RESET:     rd_word.pair.value = {4'h0, set_reset_o};
      GR_ENABLE_SR:     rd_word.pair.value = {4'h0, enable_set_reset_o};
      GR_COLOR_COMPARE: rd_word.pair.value = {4'h0, color_compare_o};
      GR_DATA_ROTATE:   rd_word.pair.value = {3'b000, raster_op_o, 3'b000};
      GR_READ_MAP:      rd_word.pair.value = {6'h00, read_map_select_o};
      GR_MODE:          rd_word.pair.value = {4'h0, read_mode_o, 1'b0, write_mode_o};
      GR_DONT_CARE:     rd_word.pair.value = {4'h0, color_dont_care_o};
      GR_BIT_MASK:      rd_word.pair.value = bit_mask_o;
      GR_MAP_MASK:      rd_word.pair.value = {4'h0, map_mask_o};
      default: ;
    endcase
  end

  assign cfg_rdata_o = rd_word.raw;

  a_mem_sel_onehot: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (wb_stb_i && wb_cyc_i && !wb_tga_i) |-> $onehot(wb_sel_i));

  // Master holds the strobe until the acknowledge cycle
  a_stb_held: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (pending && !done_q) |-> (wb_stb_i && wb_cyc_i));

endmodule

//--- logic/vga_gfx_write.sv
// Graphics controller write datapath
`timescale 1ns/1ps

module vga_gfx_write import vga_gfx_pkg::*; (
  input  logic                  wb_clk_i,
  input  logic                  rst_i,
  input  logic                  mem_wr_i,
  input  logic [7:0]            cpu_byte_i,
  input  logic [8*PLANES-1:0]   latch_i,
  input  logic [PLANES-1:0]     set_reset_i,
  input  logic [PLANES-1:0]     enable_set_reset_i,
  input  logic [1:0]            raster_op_i,
  input  logic [1:0]            write_mode_i,
  input  logic [7:0]            bit_mask_i,
  input  logic [PLANES-1:0]     map_mask_i,
  output logic [8*PLANES-1:0]   plane_wdata_o,
  output logic [PLANES-1:0]     plane_we_o
);

  logic [7:0]          src_byte   [PLANES];
  logic [7:0]          rop_byte   [PLANES];
  logic [7:0]          latch_byte [PLANES];
  logic [8*PLANES-1:0] wdata;

  always_comb begin
    for (int p = 0; p < PLANES; p++) begin
      latch_byte[p] = latch_i[8*p +: 8];

      // Source byte; mode 3 falls back to mode 0
      if (write_mode_i == 2'd2) begin
        src_byte[p] = {8{cpu_byte_i[p]}};
      end else if (enable_set_reset_i[p]) begin
        src_byte[p] = {8{set_reset_i[p]}};
      end else begin
        src_byte[p] = cpu_byte_i;
      end

      // ALU against the plane latch
      case (raster_op_i)
        ROP_AND:  rop_byte[p] = src_byte[p] & latch_byte[p];
        ROP_OR:   rop_byte[p] = src_byte[p] | latch_byte[p];
        ROP_XOR:  rop_byte[p] = src_byte[p] ^ latch_byte[p];
        ROP_NONE: rop_byte[p] = src_byte[p];
        default:  rop_byte[p] = src_byte[p];
      endcase

      // Mode 1 is a straight latch copy
      if (write_mode_i == 2'd1) begin
        wdata[8*p +: 8] = latch_byte[p];
      end else begin
        wdata[8*p +: 8] = (rop_byte[p] & bit_mask_i) | (latch_byte[p] & ~bit_mask_i);
      end
    end
  end

  // Enables and data line up for the plane write one edge later
  always_ff @(posedge wb_clk_i) begin
    if (rst_i) begin
      plane_we_o <= '0;
    end else begin
      plane_we_o <= {PLANES{mem_wr_i}} & map_mask_i;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (mem_wr_i) begin
      plane_wdata_o <= wdata;
    end
  end

  // A write strobe lasts one cycle, so the enables do too
  a_we_pulse: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (plane_we_o != '0) |=> (plane_we_o == '0));

endmodule

//--- vga_gfx.f
logic/vga_gfx_pkg.sv
logic/vga_gfx_regs.sv
logic/vga_gfx_write.sv
logic/vga_gfx_planes.sv
logic/vga_gfx_read.sv
logic/vga_gfx.sv
dv/vga_gfx_model.sv
dv/vga_gfx_tb.sv
